/* include/stamofu_defs.svh */
// ----------------------------------------------------------
// sizing macros for the store-AMO address pipeline
// register file geometry, queue index and address fields
// ----------------------------------------------------------
`ifndef STAMOFU_DEFS_SVH
`define STAMOFU_DEFS_SVH

// register file banks and read ports
`define PRF_BANK_COUNT      4
`define LOG_PRF_BANK_COUNT  2
`define PRF_READ_PORTS      2

// completion queue index
`define LOG_CQ_ENTRIES      4

// virtual address split
`define VPN_WIDTH           20
`define PO_WIDTH            12

// data and address width
`define XLEN                32

`endif

/* verilog/stamofu_pkg.sv */
// ----------------------------------------------------------
// shared types for the store-AMO address pipeline
// op and state enums, issue, launch and request structs
// ----------------------------------------------------------
`default_nettype none
`include "stamofu_defs.svh"

package stamofu_pkg;

    typedef enum logic [1:0] {MEM_SB, MEM_SH, MEM_SW, MEM_AMO} mem_op_t;

    typedef enum logic [1:0] {REQ_IDLE, REQ_ACTIVE, REQ_SECOND} req_state_t;

    // where an operand comes from
    typedef struct packed {
        logic                             forward;
        logic                             is_zero;
        logic [`LOG_PRF_BANK_COUNT-1:0]   bank;
    } operand_src_t;

    typedef struct packed {
        mem_op_t                          op;
        logic [11:0]                      imm12;
        operand_src_t                     a_src;
        operand_src_t                     b_src;
        logic [`LOG_CQ_ENTRIES-1:0]       cq_index;
    } issue_t;

    // one-cycle read ack from the register file
    typedef struct packed {
        logic                                 ack;
        logic [$clog2(`PRF_READ_PORTS)-1:0]   port;
    } reg_read_t;

    typedef logic [`PRF_BANK_COUNT-1:0][`PRF_READ_PORTS-1:0][`XLEN-1:0] prf_read_data_t;
    typedef logic [`PRF_BANK_COUNT-1:0][`XLEN-1:0] prf_fwd_data_t;

    // ----------------------------------------------------------
    // stage payloads

    typedef struct packed {
        mem_op_t                          op;
        logic [11:0]                      imm12;
        logic [`XLEN-1:0]                 a;
        logic [`XLEN-1:0]                 b;
        logic [`LOG_CQ_ENTRIES-1:0]       cq_index;
    } launch_t;

    typedef struct packed {
        mem_op_t                          op;
        logic                             is_mq;
        logic                             misaligned;
        logic                             misaligned_exception;
        logic [`VPN_WIDTH-1:0]            vpn;
        logic [`PO_WIDTH-3:0]             po_word;
        logic [3:0]                       byte_mask;
        logic [`XLEN-1:0]                 write_data;
        logic [`LOG_CQ_ENTRIES-1:0]       cq_index;
    } mem_req_t;

endpackage

`default_nettype wire

/* verilog/store_lane_align.sv */
// ----------------------------------------------------------
// byte lane decode for a store or AMO access
// byte mask, rotated write data, misalignment flags
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "stamofu_defs.svh"

module store_lane_align
    import stamofu_pkg::*;
(
    input  wire mem_op_t         op,
    input  wire [1:0]            va_low,
    input  wire                  second,
    input  wire [`XLEN-1:0]      b,
    output logic [3:0]           byte_mask,
    output logic [`XLEN-1:0]     write_data,
    output logic                 misaligned,
    output logic                 misaligned_exception
);

    // word pattern from the offset up to lane 3
    logic [3:0] word_mask;

    assign word_mask = 4'b1111 << va_low;

    always_comb begin
        case (op)
            MEM_SB: byte_mask = 4'b0001 << va_low;
            // upper lane spills into the next word at offset 3
            MEM_SH: byte_mask = second ? 4'b0001 : (4'b0011 << va_low);
            MEM_SW: byte_mask = second ? ~word_mask : word_mask;
            default: byte_mask = word_mask;
        endcase
    end

    // rotate B left by whole bytes so lane n carries byte n of the access
    always_comb begin
        case (va_low)
            2'd0: write_data = b;
            2'd1: write_data = {b[`XLEN-9:0], b[`XLEN-1:`XLEN-8]};
            2'd2: write_data = {b[`XLEN-17:0], b[`XLEN-1:`XLEN-16]};
            default: write_data = {b[`XLEN-25:0], b[`XLEN-1:`XLEN-24]};
        endcase
    end

    assign misaligned = ((op == MEM_SW) && (va_low != 2'd0))
                      || ((op == MEM_SH) && (va_low == 2'd3));

    // AMOs must be word aligned
    assign misaligned_exception = (op == MEM_AMO) && (va_low != 2'd0);

endmodule

`default_nettype wire

/* verilog/operand_collect.sv */
// ----------------------------------------------------------
// operand collection stage
// holds one issued op until both operands are present
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "stamofu_defs.svh"

module operand_collect
    import stamofu_pkg::*;
(
    input  wire                  CLK,
    input  wire                  nRST,

    // issue queue side
    input  wire                  issue_valid,
    input  wire issue_t          issue,
    output logic                 issue_ready,

    // register file side
    input  wire reg_read_t       a_read,
    input  wire reg_read_t       b_read,
    input  wire prf_read_data_t  reg_read_data,
    input  wire prf_fwd_data_t   forward_data,

    // towards REQ
    input  wire                  req_stall,
    output logic                 launch_valid,
    output launch_t              launch
);

    logic               valid_oc;
    issue_t             op_oc;
    logic               a_saved;
    logic               b_saved;
    logic [`XLEN-1:0]   a_saved_data;
    logic [`XLEN-1:0]   b_saved_data;

    logic [`XLEN-1:0]   a_val;
    logic [`XLEN-1:0]   b_val;
    logic               a_present;
    logic               b_present;
    logic               launching;

    // zero beats saved beats forward beats the register read
    function automatic logic [`XLEN-1:0] select_operand(
        input operand_src_t      src,
        input logic              saved,
        input logic [`XLEN-1:0]  saved_data,
        input reg_read_t         rd,
        input prf_read_data_t    rdata,
        input prf_fwd_data_t     fdata
    );
        if (src.is_zero) begin
            return '0;
        end else if (saved) begin
            return saved_data;
        end else if (src.forward) begin
            return fdata[src.bank];
        end else begin
            return rdata[src.bank][rd.port];
        end
    endfunction

    // ----------------------------------------------------------
    // operand select and launch

    assign a_val = select_operand(op_oc.a_src, a_saved, a_saved_data, a_read,
                                  reg_read_data, forward_data);
    assign b_val = select_operand(op_oc.b_src, b_saved, b_saved_data, b_read,
                                  reg_read_data, forward_data);

    assign a_present = op_oc.a_src.is_zero | a_saved | op_oc.a_src.forward | a_read.ack;
    assign b_present = op_oc.b_src.is_zero | b_saved | op_oc.b_src.forward | b_read.ack;

    assign launch_valid = valid_oc & a_present & b_present;
    assign launching    = launch_valid & ~req_stall;
    assign issue_ready  = ~valid_oc | launching;

    assign launch.op       = op_oc.op;
    assign launch.imm12    = op_oc.imm12;
    assign launch.a        = a_val;
    assign launch.b        = b_val;
    assign launch.cq_index = op_oc.cq_index;

    // ----------------------------------------------------------
    // holding registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_oc <= 1'b0;
            a_saved  <= 1'b0;
            b_saved  <= 1'b0;
        end else if (issue_ready) begin
            valid_oc <= issue_valid;
            a_saved  <= 1'b0;
            b_saved  <= 1'b0;
        end else begin
            // forward and ack values only last one cycle
            a_saved  <= a_present;
            b_saved  <= b_present;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            op_oc <= issue;
        end else begin
            a_saved_data <= a_val;
            b_saved_data <= b_val;
        end
    end

    // a read ack must belong to an operand that waits on the register file
    a_ack_read_only: assert property (@(posedge CLK) disable iff (!nRST)
        valid_oc && a_read.ack |-> !op_oc.a_src.is_zero && !op_oc.a_src.forward);

    b_ack_read_only: assert property (@(posedge CLK) disable iff (!nRST)
        valid_oc && b_read.ack |-> !op_oc.b_src.is_zero && !op_oc.b_src.forward);

endmodule

`default_nettype wire

/* verilog/store_req_stage.sv */
// ----------------------------------------------------------
// request stage
// address adder, held launch payload and request FSM
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "stamofu_defs.svh"

module store_req_stage
    import stamofu_pkg::*;
(
    input  wire                  CLK,
    input  wire                  nRST,

    input  wire                  launch_valid,
    input  wire launch_t         launch,
    output logic                 req_stall,

    // lane align
    output mem_op_t              op,
    output logic [1:0]           va_low,
    output logic                 second,
    output logic [`XLEN-1:0]     b,
    input  wire [3:0]            byte_mask,
    input  wire [`XLEN-1:0]      write_data,
    input  wire                  misaligned,
    input  wire                  misaligned_exception,

    // memory request
    output logic                 req_valid,
    output mem_req_t             req,
    input  wire                  req_ack
);

    req_state_t         state;
    req_state_t         next_state;
    launch_t            held;
    logic [`XLEN-1:0]   va;
    logic [`XLEN-1:0]   addr;

    // stores add the immediate, AMOs use A as is
    assign va = (held.op == MEM_AMO) ? held.a
              : held.a + {{(`XLEN-12){held.imm12[11]}}, held.imm12};

    // second access goes to the next word
    assign addr = second ? va + `XLEN'd4 : va;

    assign op     = held.op;
    assign va_low = va[1:0];
    assign second = (state == REQ_SECOND);
    assign b      = held.b;

    // ----------------------------------------------------------
    // request FSM

    always_comb begin
        next_state = state;
        req_stall  = 1'b1;
        case (state)
            REQ_IDLE: begin
                req_stall = 1'b0;
                if (launch_valid) begin
                    next_state = REQ_ACTIVE;
                end
            end
            REQ_ACTIVE: begin
                if (req_ack && misaligned) begin
                    next_state = REQ_SECOND;
                end else if (req_ack || misaligned_exception) begin
                    // exception leaves without an ack
                    req_stall  = 1'b0;
                    next_state = launch_valid ? REQ_ACTIVE : REQ_IDLE;
                end
            end
            REQ_SECOND: begin
                if (req_ack) begin
                    req_stall  = 1'b0;
                    next_state = launch_valid ? REQ_ACTIVE : REQ_IDLE;
                end
            end
            default: next_state = REQ_IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= REQ_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (launch_valid && !req_stall) begin
            held <= launch;
        end
    end

    // ----------------------------------------------------------
    // request fields

    assign req_valid                = (state != REQ_IDLE);
    assign req.op                   = held.op;
    assign req.is_mq                = second;
    assign req.misaligned           = misaligned;
    assign req.misaligned_exception = misaligned_exception;
    assign req.vpn                  = addr[`XLEN-1:`XLEN-`VPN_WIDTH];
    assign req.po_word              = addr[`XLEN-`VPN_WIDTH-1:2];
    assign req.byte_mask            = byte_mask;
    assign req.write_data           = write_data;
    assign req.cq_index             = held.cq_index;

    // a pending request holds its fields until memory takes it
    req_hold_stable: assert property (@(posedge CLK) disable iff (!nRST)
        req_valid && !req_ack && !req.misaligned_exception |=> $stable(req));

endmodule

`default_nettype wire

/* verilog/stamofu_addr_pipeline.sv */
// ----------------------------------------------------------
// store-AMO address pipeline top level
// operand collection feeding the request stage
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "stamofu_defs.svh"

module stamofu_addr_pipeline
    import stamofu_pkg::*;
(
    input  wire                  CLK,
    input  wire                  nRST,

    input  wire                  issue_valid,
    input  wire issue_t          issue,
    output logic                 issue_ready,

    input  wire reg_read_t       a_read,
    input  wire reg_read_t       b_read,
    input  wire prf_read_data_t  reg_read_data,
    input  wire prf_fwd_data_t   forward_data,

    output logic                 req_valid,
    output mem_req_t             req,
    input  wire                  req_ack
);

    // OC to REQ
    logic               launch_valid;
    launch_t            launch;
    logic               req_stall;

    // REQ to lane align and back
    mem_op_t            align_op;
    logic [1:0]         align_va_low;
    logic               align_second;
    logic [`XLEN-1:0]   align_b;
    logic [3:0]         byte_mask;
    logic [`XLEN-1:0]   write_data;
    logic               misaligned;
    logic               misaligned_exception;

    operand_collect i_operand_collect (
        .CLK           (CLK),
        .nRST          (nRST),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .issue_ready   (issue_ready),
        .a_read        (a_read),
        .b_read        (b_read),
        .reg_read_data (reg_read_data),
        .forward_data  (forward_data),
        .req_stall     (req_stall),
        .launch_valid  (launch_valid),
        .launch        (launch)
    );

    store_req_stage i_store_req_stage (
        .CLK                  (CLK),
        .nRST                 (nRST),
        .launch_valid         (launch_valid),
        .launch               (launch),
        .req_stall            (req_stall),
        .op                   (align_op),
        .va_low               (align_va_low),
        .second               (align_second),
        .b                    (align_b),
        .byte_mask            (byte_mask),
        .write_data           (write_data),
        .misaligned           (misaligned),
        .misaligned_exception (misaligned_exception),
        .req_valid            (req_valid),
        .req                  (req),
        .req_ack              (req_ack)
    );

    store_lane_align i_store_lane_align (
        .op                   (align_op),
        .va_low               (align_va_low),
        .second               (align_second),
        .b                    (align_b),
        .byte_mask            (byte_mask),
        .write_data           (write_data),
        .misaligned           (misaligned),
        .misaligned_exception (misaligned_exception)
    );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
// ----------------------------------------------------------
// testbench clock and reset generator
// 10 ns clock, reset held low for the first cycles
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 4
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // release on a rising edge
    initial begin
        nRST <= 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

`default_nettype wire

/* bench/tb_stamofu_addr_pipeline.sv */
// ----------------------------------------------------------
// testbench for the store-AMO address pipeline
// random ops and operand sources, request model, compare tasks
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "stamofu_defs.svh"

module tb_stamofu_addr_pipeline
    import stamofu_pkg::*;
();

    localparam int          NUM_OPS    = 300;
    localparam int          WAIT_LIMIT = 200;
    localparam int          IDLE_TAIL  = 4;
    localparam logic [31:0] LFSR_SEED  = 32'h2d4a;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

    logic            CLK;
    logic            nRST;
    logic            issue_valid;
    issue_t          issue;
    logic            issue_ready;
    reg_read_t       a_read;
    reg_read_t       b_read;
    prf_read_data_t  reg_read_data;
    prf_fwd_data_t   forward_data;
    logic            req_valid;
    mem_req_t        req;
    logic            req_ack;

    // expected requests in issue order
    mem_req_t        exp_reqs[$];
    logic            exp_last[$];
    logic [31:0]     stim_state;
    int              issued_ops;
    int              done_ops;
    int              head;

    tb_clock_gen i_clock_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    stamofu_addr_pipeline i_stamofu_addr_pipeline (
        .CLK           (CLK),
        .nRST          (nRST),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .issue_ready   (issue_ready),
        .a_read        (a_read),
        .b_read        (b_read),
        .reg_read_data (reg_read_data),
        .forward_data  (forward_data),
        .req_valid     (req_valid),
        .req           (req),
        .req_ack       (req_ack)
    );

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(inout logic [31:0] state, input int n);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < n; i++) begin
            out_bit = state[0];
            state   = state >> 1;
            if (out_bit) begin
                state = state ^ LFSR_TAPS;
            end
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t expected);
        if (got !== expected) begin
            $display("FAIL req got %h expected %h", got, expected);
            abort_run();
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAIL %s got %h expected %h", name, got, expected);
            abort_run();
        end
    endtask

    // ----------------------------------------------------------
    // reference model

    task automatic expect_requests(input issue_t op_in, input logic [31:0] a,
                                   input logic [31:0] b);
        logic [31:0] va;
        logic [31:0] next_va;
        logic [3:0]  mask_lo;
        logic [3:0]  mask_hi;
        logic [31:0] wd;
        logic        split;
        int          off;
        mem_req_t    r;
        va  = (op_in.op == MEM_AMO) ? a : a + {{20{op_in.imm12[11]}}, op_in.imm12};
        off = {30'b0, va[1:0]};
        for (int lane = 0; lane < 4; lane++) begin
            // byte n of B lands on lane n plus the offset
            wd[8*((lane + off) % 4) +: 8] = b[8*lane +: 8];
            case (op_in.op)
                MEM_SB:  mask_lo[lane] = (lane == off);
                MEM_SH:  mask_lo[lane] = (lane == off) || (lane == off + 1);
                default: mask_lo[lane] = (lane >= off);
            endcase
            mask_hi[lane] = (op_in.op == MEM_SH) ? (lane == 0) : (lane < off);
        end
        split = ((op_in.op == MEM_SW) && (off != 0)) || ((op_in.op == MEM_SH) && (off == 3));
        r.op                   = op_in.op;
        r.is_mq                = 1'b0;
        r.misaligned           = split;
        r.misaligned_exception = (op_in.op == MEM_AMO) && (off != 0);
        r.vpn                  = va[`XLEN-1:`PO_WIDTH];
        r.po_word              = va[`PO_WIDTH-1:2];
        r.byte_mask            = mask_lo;
        r.write_data           = wd;
        r.cq_index             = op_in.cq_index;
        exp_reqs.push_back(r);
        exp_last.push_back(!split);
        if (split) begin
            next_va     = va + 32'd4;
            r.is_mq     = 1'b1;
            r.vpn       = next_va[`XLEN-1:`PO_WIDTH];
            r.po_word   = next_va[`PO_WIDTH-1:2];
            r.byte_mask = mask_hi;
            exp_reqs.push_back(r);
            exp_last.push_back(1'b1);
        end
    endtask

    // ----------------------------------------------------------
    // stimulus

    task automatic issue_one();
        issue_t          op_in;
        logic [31:0]     r;
        logic [31:0]     a_val;
        logic [31:0]     b_val;
        logic [1:0]      a_kind;
        logic [1:0]      b_kind;
        logic            a_port;
        logic            b_port;
        int              a_delay;
        int              b_delay;
        int              gap;
        int              waited;
        prf_read_data_t  rd;
        prf_fwd_data_t   fd;
        reg_read_t       a_rd;
        reg_read_t       b_rd;
        r                = rand_bits(stim_state, 32);
        op_in.op         = mem_op_t'(r[1:0]);
        op_in.imm12      = r[13:2];
        op_in.cq_index   = r[17:14];
        a_kind           = r[19:18];
        b_kind           = r[21:20];
        op_in.a_src.bank = r[23:22];
        op_in.b_src.bank = r[25:24];
        a_port           = r[26];
        b_port           = r[27];
        a_delay          = {30'b0, r[29:28]};
        b_delay          = {30'b0, r[31:30]};
        // kind 0 zero, 1 forward, otherwise register read
        op_in.a_src.is_zero = (a_kind == 2'd0);
        op_in.a_src.forward = (a_kind == 2'd1);
        op_in.b_src.is_zero = (b_kind == 2'd0);
        op_in.b_src.forward = (b_kind == 2'd1);
        // one value per forward bank and per read slot
        if (op_in.a_src.forward && op_in.b_src.forward
                && op_in.a_src.bank == op_in.b_src.bank) begin
            op_in.b_src.bank = op_in.a_src.bank ^ 2'd1;
        end
        if (a_kind[1] && b_kind[1] && a_delay == b_delay
                && op_in.a_src.bank == op_in.b_src.bank) begin
            b_port = ~a_port;
        end
        a_val = op_in.a_src.is_zero ? 32'd0 : rand_bits(stim_state, 32);
        b_val = op_in.b_src.is_zero ? 32'd0 : rand_bits(stim_state, 32);
        gap   = rand_bits(stim_state, 2);
        repeat (gap) @(posedge CLK);

        issue_valid <= 1'b1;
        issue       <= op_in;
        waited = 0;
        @(negedge CLK);
        while (!issue_ready) begin
            if (waited == WAIT_LIMIT) begin
                $display("issue_ready stayed low for %0d cycles", WAIT_LIMIT);
                abort_run();
            end
            waited++;
            @(negedge CLK);
        end
        @(posedge CLK);

        // op sits in OC from this edge
        issue_valid <= 1'b0;
        expect_requests(op_in, a_val, b_val);
        issued_ops++;
        for (int cyc = 0; cyc < 4; cyc++) begin
            for (int bk = 0; bk < `PRF_BANK_COUNT; bk++) begin
                fd[bk] = rand_bits(stim_state, 32);
                for (int pt = 0; pt < `PRF_READ_PORTS; pt++) begin
                    rd[bk][pt] = rand_bits(stim_state, 32);
                end
            end
            a_rd = '0;
            b_rd = '0;
            if (cyc == 0 && op_in.a_src.forward) begin
                fd[op_in.a_src.bank] = a_val;
            end
            if (cyc == 0 && op_in.b_src.forward) begin
                fd[op_in.b_src.bank] = b_val;
            end
            if (a_kind[1] && cyc == a_delay) begin
                rd[op_in.a_src.bank][a_port] = a_val;
                a_rd.ack  = 1'b1;
                a_rd.port = a_port;
            end
            if (b_kind[1] && cyc == b_delay) begin
                rd[op_in.b_src.bank][b_port] = b_val;
                b_rd.ack  = 1'b1;
                b_rd.port = b_port;
            end
            reg_read_data <= rd;
            forward_data  <= fd;
            a_read        <= a_rd;
            b_read        <= b_rd;
            @(posedge CLK);
        end
        a_read <= '0;
        b_read <= '0;
    endtask

    initial begin : stimulus
        int waited;
        stim_state     = LFSR_SEED;
        issued_ops     = 0;
        issue_valid   <= 1'b0;
        issue         <= '0;
        a_read        <= '0;
        b_read        <= '0;
        reg_read_data <= '0;
        forward_data  <= '0;
        waited = 0;
        @(posedge CLK);
        while (!nRST) begin
            if (waited == WAIT_LIMIT) begin
                $display("reset was never released");
                abort_run();
            end
            waited++;
            @(posedge CLK);
        end
        @(negedge CLK);
        check_ready("issue_ready", issue_ready, 1'b1);
        check_ready("req_valid", req_valid, 1'b0);
        @(posedge CLK);

        repeat (NUM_OPS) issue_one();

        waited = 0;
        @(negedge CLK);
        while (done_ops != issued_ops) begin
            if (waited == WAIT_LIMIT) begin
                $display("outstanding ops never completed");
                abort_run();
            end
            waited++;
            @(negedge CLK);
        end
        // the last request drains and nothing follows it
        repeat (IDLE_TAIL) begin
            @(negedge CLK);
            check_ready("req_valid", req_valid, 1'b0);
        end
        $display("Verification passed");
        $finish;
    end

    // random ack delays and a long quiet stretch every 100 cycles
    initial begin : ack_driver
        logic [31:0] ack_state;
        int          cycle;
        ack_state = LFSR_SEED;
        cycle     = 0;
        req_ack  <= 1'b0;
        forever begin
            @(posedge CLK);
            cycle++;
            if (cycle % 100 >= 75) begin
                req_ack <= 1'b0;
            end else begin
                req_ack <= (rand_bits(ack_state, 2) != 32'd0);
            end
        end
    end

    // ----------------------------------------------------------
    // response checks at mid-cycle

    initial begin : monitor
        done_ops = 0;
        head     = 0;
        forever begin
            @(negedge CLK);
            if (nRST) begin
                if (issued_ops == done_ops) begin
                    check_ready("issue_ready", issue_ready, 1'b1);
                end else if (issued_ops - done_ops >= 2 && !req_ack
                             && !exp_reqs[head].misaligned_exception) begin
                    // REQ busy with the oldest op and OC full with the next
                    check_ready("issue_ready", issue_ready, 1'b0);
                end
                if (req_valid) begin
                    if (head >= exp_reqs.size()) begin
                        $display("request seen with no op outstanding");
                        abort_run();
                    end
                    check_req(req, exp_reqs[head]);
                    if (req_ack || exp_reqs[head].misaligned_exception) begin
                        if (exp_last[head]) begin
                            done_ops++;
                        end
                        head++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
verilog/stamofu_pkg.sv
verilog/store_lane_align.sv
verilog/operand_collect.sv
verilog/store_req_stage.sv
verilog/stamofu_addr_pipeline.sv
bench/tb_clock_gen.sv
bench/tb_stamofu_addr_pipeline.sv

/* Makefile */
SIM        = verilator
FILELIST   = filelist.f
TOP        = tb_stamofu_addr_pipeline
RTL_TOP    = stamofu_addr_pipeline
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
PASS_TEXT  = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
